/* include/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// word and line widths
`define XLEN            32
`define INST_WIDTH      32
`define LINE_WIDTH      64

// byte steps through the line
`define INST_BYTES      4
`define FETCH_STRIDE    8

// table indices start right above the byte offset
`define IDX_LSB         2

// branch target buffer geometry
`define BTB_SIZE        256
`define BTB_TAG_SIZE    10
`define BTB_VAL_SIZE    12

// local history table, one 3 bit history per entry
`define BHT_SIZE        256
`define BHT_WIDTH       3

// counter value after reset, weak not-taken
`define PHT_INIT        2'b01

// opcode field and the two opcodes the pre-decoder looks for
`define OPCODE_WIDTH    7
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_JAL      7'b1101111

`endif

/* verilog/fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache line, seen either whole or as two instruction slots
    ////////////////////////////////////////////////////////////////////////////

    // raw is what the cache hands over
    // slot[0] sits in the low word, slot[1] in the high word
    typedef union packed {
        logic [`LINE_WIDTH-1:0]             raw;
        logic [1:0][`INST_WIDTH-1:0]        slot;
    } fetch_line_u;

    ////////////////////////////////////////////////////////////////////////////
    // 2 bit saturating direction counter
    ////////////////////////////////////////////////////////////////////////////

    // msb set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } pht_state_e;

endpackage

/* verilog/branch_predecode.sv */
`include "fetch_cfg.svh"

module branch_predecode import fetch_pkg::*; (
    input  fetch_line_u         line,
    input  logic                line_valid,
    output logic [1:0]          cond_branch,
    output logic [1:0]          jump
);

    // opcode of each slot, low bits of the instruction word
    logic [1:0][`OPCODE_WIDTH-1:0] opcode;

    ////////////////////////////////////////////////////////////////////////////
    // opcode extraction
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            opcode[i] = line.slot[i][`OPCODE_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////////////////////

    // only conditional branches and JAL matter here
    // JALR falls through as an ordinary instruction
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // beq/bne/blt/bge/bltu/bgeu all share one opcode
            cond_branch[i] = line_valid && (opcode[i] == `OPCODE_BRANCH);
            // direct jump, target comes from the BTB
            jump[i]        = line_valid && (opcode[i] == `OPCODE_JAL);
        end
    end

endmodule

/* verilog/branch_target_buffer.sv */
`include "fetch_cfg.svh"

module branch_target_buffer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`XLEN-1:0]            fetch_pc,
    input  logic [1:0]                  ex_br_en,
    input  logic [1:0][`XLEN-1:0]       ex_pc,
    input  logic [1:0][`XLEN-1:0]       ex_tg_pc,
    output logic [1:0]                  btb_hit,
    output logic [1:0][`XLEN-1:0]       btb_target
);

    localparam int IDX_W   = $clog2(`BTB_SIZE);
    // tag sits right above the index
    localparam int TAG_LSB = `IDX_LSB + IDX_W;

    // tag and partial target per entry
    logic [`BTB_TAG_SIZE-1:0]   tag_mem [`BTB_SIZE];
    logic [`BTB_VAL_SIZE-1:0]   val_mem [`BTB_SIZE];
    logic [`BTB_SIZE-1:0]       valid;

    logic [1:0][`XLEN-1:0]      rd_pc;
    logic [1:0][IDX_W-1:0]      rd_idx;
    logic [1:0][IDX_W-1:0]      wr_idx;
    logic [1:0]                 wr_en;

    ////////////////////////////////////////////////////////////////////////////
    // training from execute
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_idx[i] = ex_pc[i][`IDX_LSB +: IDX_W];
        end
        // same index in one cycle, slot 0 wins
        wr_en[0] = ex_br_en[0];
        wr_en[1] = ex_br_en[1] && !(ex_br_en[0] && (wr_idx[0] == wr_idx[1]));
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wr_en[i]) begin
                    valid[wr_idx[i]] <= 1'b1;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_en[i]) begin
                tag_mem[wr_idx[i]] <= ex_pc[i][TAG_LSB +: `BTB_TAG_SIZE];
                val_mem[wr_idx[i]] <= ex_tg_pc[i][`IDX_LSB +: `BTB_VAL_SIZE];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lookup for both fetch slots
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_pc[0] = fetch_pc;
        rd_pc[1] = fetch_pc + `INST_BYTES;
        for (int i = 0; i < 2; i++) begin
            rd_idx[i]  = rd_pc[i][`IDX_LSB +: IDX_W];
            btb_hit[i] = valid[rd_idx[i]] &&
                         (tag_mem[rd_idx[i]] == rd_pc[i][TAG_LSB +: `BTB_TAG_SIZE]);
            // upper bits borrowed from the fetch PC, word aligned
            btb_target[i] = {fetch_pc[`XLEN-1:`IDX_LSB+`BTB_VAL_SIZE],
                             val_mem[rd_idx[i]],
                             {`IDX_LSB{1'b0}}};
        end
    end

endmodule

/* verilog/branch_direction_predictor.sv */
`include "fetch_cfg.svh"

module branch_direction_predictor import fetch_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`XLEN-1:0]            fetch_pc,
    input  logic [1:0]                  ex_cond_en,
    input  logic [1:0][`XLEN-1:0]       ex_pc,
    input  logic [1:0]                  ex_taken,
    output logic [1:0]                  predict_taken
);

    localparam int IDX_W    = $clog2(`BHT_SIZE);
    // one counter per history pattern
    localparam int PHT_WAYS = 2 ** `BHT_WIDTH;

    // local histories, newest outcome in bit 0
    logic [`BHT_WIDTH-1:0]      bht [`BHT_SIZE];
    // pattern counters, indexed by entry then history
    pht_state_e                 pht [`BHT_SIZE][PHT_WAYS];

    logic [1:0][`XLEN-1:0]      rd_pc;
    logic [1:0][IDX_W-1:0]      rd_idx;
    logic [1:0][`BHT_WIDTH-1:0] rd_hist;

    logic [1:0][IDX_W-1:0]      wr_idx;
    logic [1:0][`BHT_WIDTH-1:0] old_hist;
    logic [1:0]                 wr_en;
    pht_state_e                 new_cnt [2];

    // saturating step, weak NT jumps straight to strong T on taken
    function automatic pht_state_e step_counter(input pht_state_e cur, input logic taken);
        pht_state_e nxt;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? STRONG_T : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : STRONG_NT;
            default:   nxt = taken ? STRONG_T : WEAK_T;
        endcase
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // prediction read
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_pc[0] = fetch_pc;
        rd_pc[1] = fetch_pc + `INST_BYTES;
        for (int i = 0; i < 2; i++) begin
            rd_idx[i]  = rd_pc[i][`IDX_LSB +: IDX_W];
            rd_hist[i] = bht[rd_idx[i]];
            // weak or strong taken
            predict_taken[i] = pht[rd_idx[i]][rd_hist[i]][1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // training from execute
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_idx[i]   = ex_pc[i][`IDX_LSB +: IDX_W];
            // counter chosen by history before the shift
            old_hist[i] = bht[wr_idx[i]];
            new_cnt[i]  = step_counter(pht[wr_idx[i]][old_hist[i]], ex_taken[i]);
        end
        // shared index, keep slot 0 only
        wr_en[0] = ex_cond_en[0];
        wr_en[1] = ex_cond_en[1] && !(ex_cond_en[0] && (wr_idx[0] == wr_idx[1]));
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < `BHT_SIZE; e++) begin
                bht[e] <= '0;
                for (int w = 0; w < PHT_WAYS; w++) begin
                    pht[e][w] <= pht_state_e'(`PHT_INIT);
                end
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wr_en[i]) begin
                    // shift in the resolved outcome
                    bht[wr_idx[i]] <= {old_hist[i][`BHT_WIDTH-2:0], ex_taken[i]};
                    pht[wr_idx[i]][old_hist[i]] <= new_cnt[i];
                end
            end
        end
    end

endmodule

/* verilog/next_pc_select.sv */
`include "fetch_cfg.svh"

module next_pc_select (
    input  logic [`XLEN-1:0]            fetch_pc,
    input  logic                        take_branch,
    input  logic [`XLEN-1:0]            branch_target,
    input  logic [1:0]                  cond_branch,
    input  logic [1:0]                  jump,
    input  logic [1:0]                  btb_hit,
    input  logic [1:0][`XLEN-1:0]       btb_target,
    input  logic [1:0]                  predict_taken,
    output logic [`XLEN-1:0]            next_pc,
    output logic [`XLEN-1:0]            slot0_npc,
    output logic                        slot1_live
);

    // per slot redirect decision
    logic [1:0] slot_taken;

    ////////////////////////////////////////////////////////////////////////////
    // per slot prediction
    ////////////////////////////////////////////////////////////////////////////

    // a hit is required either way
    // JAL always goes, a branch goes on its counter
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot_taken[i] = btb_hit[i] && (jump[i] || (cond_branch[i] && predict_taken[i]));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next fetch address
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (take_branch) begin
            // backend redirect beats any prediction
            next_pc = branch_target;
        end else if (slot_taken[0]) begin
            next_pc = btb_target[0];
        end else if (slot_taken[1]) begin
            next_pc = btb_target[1];
        end else begin
            // sequential, skip the whole line
            next_pc = fetch_pc + `FETCH_STRIDE;
        end
    end

    // slot 0 either jumps or falls into slot 1
    assign slot0_npc  = slot_taken[0] ? btb_target[0] : fetch_pc + `INST_BYTES;

    // slot 1 is dead behind a taken slot 0
    assign slot1_live = !slot_taken[0];

endmodule

/* verilog/fetch_stage.sv */
`include "fetch_cfg.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        if_valid,
    input  logic                        take_branch,
    input  logic [`XLEN-1:0]            branch_target,
    input  logic                        icache_valid,
    input  logic [`LINE_WIDTH-1:0]      icache_data,
    input  logic [1:0]                  ex_br_en,
    input  logic [1:0]                  ex_cond_en,
    input  logic [1:0][`XLEN-1:0]       ex_pc,
    input  logic [1:0][`XLEN-1:0]       ex_tg_pc,
    input  logic [1:0]                  ex_taken,
    output logic [`XLEN-1:0]            icache_addr,
    output logic [1:0]                  slot_valid,
    output logic [1:0][`INST_WIDTH-1:0] slot_inst,
    output logic [1:0][`XLEN-1:0]       slot_pc,
    output logic [1:0][`XLEN-1:0]       slot_npc
);

    logic [`XLEN-1:0]       fetch_pc;
    logic [`XLEN-1:0]       next_pc;
    logic [`XLEN-1:0]       slot0_npc;
    logic                   slot1_live;
    logic                   pc_load;
    fetch_line_u            line;

    logic [1:0]             cond_branch;
    logic [1:0]             jump;
    logic [1:0]             btb_hit;
    logic [1:0][`XLEN-1:0]  btb_target;
    logic [1:0]             predict_taken;

    ////////////////////////////////////////////////////////////////////////////
    // PC register
    ////////////////////////////////////////////////////////////////////////////

    // advance on a delivered line, or jump on a redirect regardless
    assign pc_load = (icache_valid && if_valid) || take_branch;

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= '0;
        end else if (pc_load) begin
            fetch_pc <= next_pc;
        end
    end

    // word aligned request to the cache
    assign icache_addr = {fetch_pc[`XLEN-1:2], 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // predictor
    ////////////////////////////////////////////////////////////////////////////

    assign line.raw = icache_data;

    branch_predecode u_predecode (
        .line           (line),
        .line_valid     (icache_valid),
        .cond_branch    (cond_branch),
        .jump           (jump)
    );

    branch_target_buffer u_btb (
        .clock          (clock),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .ex_br_en       (ex_br_en),
        .ex_pc          (ex_pc),
        .ex_tg_pc       (ex_tg_pc),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target)
    );

    branch_direction_predictor u_bdp (
        .clock          (clock),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .ex_cond_en     (ex_cond_en),
        .ex_pc          (ex_pc),
        .ex_taken       (ex_taken),
        .predict_taken  (predict_taken)
    );

    next_pc_select u_npc (
        .fetch_pc       (fetch_pc),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .cond_branch    (cond_branch),
        .jump           (jump),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .predict_taken  (predict_taken),
        .next_pc        (next_pc),
        .slot0_npc      (slot0_npc),
        .slot1_live     (slot1_live)
    );

    ////////////////////////////////////////////////////////////////////////////
    // slot outputs
    ////////////////////////////////////////////////////////////////////////////

    assign slot_inst     = line.slot;
    assign slot_valid[0] = icache_valid;
    assign slot_valid[1] = icache_valid && slot1_live;
    assign slot_pc[0]    = fetch_pc;
    assign slot_pc[1]    = fetch_pc + `INST_BYTES;
    assign slot_npc[0]   = slot0_npc;
    // slot 1 always leads to the next fetch
    assign slot_npc[1]   = next_pc;

endmodule

/* tests/fetch_checker.sv */
`include "fetch_cfg.svh"

module fetch_checker #(
    // time after the falling edge at which outputs are read
    parameter int SAMPLE_DELAY = 3
) (
    input  logic                        clock,
    input  logic                        check_en,
    input  logic [127:0]                test_name,
    input  logic [2:0]                  mask,
    input  logic [`XLEN-1:0]            exp_addr,
    input  logic [1:0]                  exp_valid,
    input  logic [`XLEN-1:0]            exp_npc0,
    input  logic [`XLEN-1:0]            exp_npc1,
    input  logic [`LINE_WIDTH-1:0]      exp_line,
    input  logic [`XLEN-1:0]            icache_addr,
    input  logic [1:0]                  slot_valid,
    input  logic [1:0][`INST_WIDTH-1:0] slot_inst,
    input  logic [1:0][`XLEN-1:0]       slot_pc,
    input  logic [1:0][`XLEN-1:0]       slot_npc,
    output int                          pass_count,
    output int                          fail_count
);

    // address, slot valids, next PCs, slot PCs and the line in one word
    localparam int VEC_W = 5 * `XLEN + 2 + `LINE_WIDTH;

    // slot 1 sits one instruction after slot 0
    logic [`XLEN-1:0] exp_pc1;
    logic [VEC_W-1:0] exp_vec;
    logic [VEC_W-1:0] act_vec;
    logic [VEC_W-1:0] care;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare once per row just before the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        #(SAMPLE_DELAY);
        if (check_en) begin
            exp_pc1 = exp_addr + `INST_BYTES;
            exp_vec = {exp_addr, exp_valid, exp_npc0, exp_npc1,
                       exp_addr, exp_pc1, exp_line};
            act_vec = {icache_addr, slot_valid, slot_npc[0], slot_npc[1],
                       slot_pc[0], slot_pc[1], slot_inst};
            // mask bit 0 for address and slot PCs
            // bit 1 for valids and instructions
            // bit 2 for next PCs
            care    = {{`XLEN{mask[0]}}, {2{mask[1]}}, {(2 * `XLEN){mask[2]}},
                       {(2 * `XLEN){mask[0]}}, {`LINE_WIDTH{mask[1]}}};
            if (((exp_vec ^ act_vec) & care) == '0) begin
                pass_count++;
                $display("PASS %0s", test_name);
            end else begin
                fail_count++;
                $display("FAIL %0s expected %h actual %h",
                         test_name, exp_vec & care, act_vec & care);
            end
        end
    end

endmodule

/* tests/fetch_stage_tb.sv */
`include "fetch_cfg.svh"

module fetch_stage_tb;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_ROWS     = 32;
    // idle cycle after reset, drain cycle, spare
    localparam int SLACK_CYCLES = 8;
    localparam logic [31:0] SEED = 32'd88932;

    localparam logic [2:0] M_ALL    = 3'b111;
    localparam logic [2:0] M_NO_NPC = 3'b011;

    // jal x1 and beq x1, x2
    localparam logic [31:0] JAL_INST = {20'h04000, 5'd1, `OPCODE_JAL};
    localparam logic [31:0] BEQ_INST = {7'd0, 5'd2, 5'd1, 3'd0, 5'd8, `OPCODE_BRANCH};
    localparam logic [6:0]  OP_IMM   = 7'b0010011;

    logic clock;
    logic reset;
    logic if_valid;
    logic take_branch;
    logic [`XLEN-1:0] branch_target;
    logic icache_valid;
    logic [`LINE_WIDTH-1:0] icache_data;
    logic [1:0] ex_br_en;
    logic [1:0] ex_cond_en;
    logic [1:0][`XLEN-1:0] ex_pc;
    logic [1:0][`XLEN-1:0] ex_tg_pc;
    logic [1:0] ex_taken;
    logic [`XLEN-1:0] icache_addr;
    logic [1:0] slot_valid;
    logic [1:0][`XLEN-1:0] slot_inst;
    logic [1:0][`XLEN-1:0] slot_pc;
    logic [1:0][`XLEN-1:0] slot_npc;

    // expected values fed to the checker
    logic check_en;
    logic [127:0] cur_name;
    logic [2:0] cur_mask;
    logic [`XLEN-1:0] cur_addr;
    logic [1:0] cur_valid;
    logic [`XLEN-1:0] cur_npc0;
    logic [`XLEN-1:0] cur_npc1;
    int pass_count;
    int fail_count;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    logic [127:0] t_name [MAX_ROWS];
    logic t_ifv [MAX_ROWS];
    logic t_icv [MAX_ROWS];
    logic [31:0] t_i0 [MAX_ROWS];
    logic [31:0] t_i1 [MAX_ROWS];
    logic t_redir [MAX_ROWS];
    logic [31:0] t_bt [MAX_ROWS];
    logic [1:0] t_br [MAX_ROWS];
    logic [1:0] t_cond [MAX_ROWS];
    logic [1:0] t_taken [MAX_ROWS];
    logic [1:0][31:0] t_pc [MAX_ROWS];
    logic [1:0][31:0] t_tg [MAX_ROWS];
    logic [31:0] t_addr [MAX_ROWS];
    logic [1:0] t_valid [MAX_ROWS];
    logic [31:0] t_npc0 [MAX_ROWS];
    logic [31:0] t_npc1 [MAX_ROWS];
    logic [2:0] t_mask [MAX_ROWS];
    int n_rows;
    logic table_ready;
    logic [31:0] lfsr_state;

    // taps for x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // random upper bits under an ALU opcode so it never predicts
    function automatic logic [31:0] fill_inst();
        logic [24:0] w;
        w = '0;
        for (int b = 0; b < 25; b++) begin
            w = {w[23:0], rand_bit()};
        end
        return {w, OP_IMM};
    endfunction

    task automatic add_row(input logic [127:0] name, input logic ifv, input logic icv,
                           input logic [31:0] i0, input logic [31:0] i1,
                           input logic [31:0] addr, input logic [1:0] valid,
                           input logic [31:0] npc0, input logic [31:0] npc1,
                           input logic [2:0] mask);
        t_name[n_rows]  = name;
        t_ifv[n_rows]   = ifv;
        t_icv[n_rows]   = icv;
        t_i0[n_rows]    = i0;
        t_i1[n_rows]    = i1;
        t_redir[n_rows] = 1'b0;
        t_bt[n_rows]    = '0;
        t_br[n_rows]    = '0;
        t_cond[n_rows]  = '0;
        t_taken[n_rows] = '0;
        t_pc[n_rows]    = '0;
        t_tg[n_rows]    = '0;
        t_addr[n_rows]  = addr;
        t_valid[n_rows] = valid;
        t_npc0[n_rows]  = npc0;
        t_npc1[n_rows]  = npc1;
        t_mask[n_rows]  = mask;
        n_rows++;
    endtask

    // these three amend the row added last
    task automatic set_redirect(input logic [31:0] target);
        t_redir[n_rows-1] = 1'b1;
        t_bt[n_rows-1]    = target;
    endtask

    task automatic btb_training(input int slot, input logic [31:0] pc, input logic [31:0] tg);
        t_br[n_rows-1][slot] = 1'b1;
        t_pc[n_rows-1][slot] = pc;
        t_tg[n_rows-1][slot] = tg;
    endtask

    task automatic history_training(input int slot, input logic [31:0] pc, input logic taken);
        t_cond[n_rows-1][slot]  = 1'b1;
        t_pc[n_rows-1][slot]    = pc;
        t_taken[n_rows-1][slot] = taken;
    endtask

    initial begin
        table_ready = 1'b0;
        n_rows      = 0;
        lfsr_state  = SEED;
        // sequential stepping from reset by 8
        add_row("seq_0", 1, 1, fill_inst(), fill_inst(), 'h0, 2'b11, 'h4, 'h8, M_ALL);
        add_row("seq_8", 1, 1, fill_inst(), fill_inst(), 'h8, 2'b11, 'hc, 'h10, M_ALL);
        add_row("seq_16", 1, 1, fill_inst(), fill_inst(), 'h10, 2'b11, 'h14, 'h18, M_ALL);
        // holds then a redirect with no line
        add_row("hold_ifv", 0, 1, fill_inst(), fill_inst(), 'h18, 2'b11, 'h1c, 'h20, M_ALL);
        add_row("hold_icv", 1, 0, fill_inst(), fill_inst(), 'h18, 2'b00, 'h1c, 'h20, M_NO_NPC);
        add_row("redirect", 1, 0, fill_inst(), fill_inst(), 'h18, 2'b00, 'h1c, 'h100, M_ALL);
        set_redirect('h100);
        add_row("redirect_lands", 1, 1, fill_inst(), fill_inst(), 'h100, 2'b11, 'h104, 'h108,
                M_ALL);
        // JAL at 0x108
        // target keeps only bits 13:2 and takes its upper bits from the fetch PC
        add_row("jal_cold", 0, 1, JAL_INST, fill_inst(), 'h108, 2'b11, 'h10c, 'h110, M_ALL);
        add_row("jal_train", 0, 0, JAL_INST, fill_inst(), 'h108, 2'b00, 'h10c, 'h110, M_NO_NPC);
        btb_training(0, 'h108, 'h0001_2340);
        add_row("jal_hit", 1, 1, JAL_INST, fill_inst(), 'h108, 2'b01, 'h2340, 'h2340, M_ALL);
        add_row("jal_lands", 1, 1, fill_inst(), fill_inst(), 'h2340, 2'b11, 'h2344, 'h2348,
                M_ALL);
        // branch in slot 1 at 0x234c
        // histories 000 001 011 111 each meet a fresh counter
        add_row("br_no_entry", 0, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2350, M_ALL);
        btb_training(1, 'h234c, 'h2000);
        add_row("br_taken_1", 0, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2350, M_ALL);
        history_training(0, 'h234c, 1'b1);
        add_row("br_taken_2", 0, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2350, M_ALL);
        history_training(1, 'h234c, 1'b1);
        add_row("br_taken_3", 0, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2350, M_ALL);
        history_training(0, 'h234c, 1'b1);
        add_row("br_taken_4", 0, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2350, M_ALL);
        history_training(1, 'h234c, 1'b1);
        // history 111 now selects a strong taken counter
        add_row("br_predicted", 1, 1, fill_inst(), BEQ_INST, 'h2348, 2'b11, 'h234c, 'h2000,
                M_ALL);
        add_row("br_lands", 1, 1, fill_inst(), fill_inst(), 'h2000, 2'b11, 'h2004, 'h2008, M_ALL);
        // both ports hit index 2 together
        add_row("dual_train", 0, 1, fill_inst(), fill_inst(), 'h2008, 2'b11, 'h200c, 'h2010,
                M_ALL);
        btb_training(0, 'h2008, 'h2400);
        btb_training(1, 'h2008, 'h2800);
        add_row("dual_hit", 1, 1, JAL_INST, fill_inst(), 'h2008, 2'b01, 'h2400, 'h2400, M_ALL);
        add_row("dual_lands", 1, 1, fill_inst(), fill_inst(), 'h2400, 2'b11, 'h2404, 'h2408,
                M_ALL);
        table_ready = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // DUT and checker
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage DUT (
        .clock          (clock),
        .reset          (reset),
        .if_valid       (if_valid),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .icache_valid   (icache_valid),
        .icache_data    (icache_data),
        .ex_br_en       (ex_br_en),
        .ex_cond_en     (ex_cond_en),
        .ex_pc          (ex_pc),
        .ex_tg_pc       (ex_tg_pc),
        .ex_taken       (ex_taken),
        .icache_addr    (icache_addr),
        .slot_valid     (slot_valid),
        .slot_inst      (slot_inst),
        .slot_pc        (slot_pc),
        .slot_npc       (slot_npc)
    );

    // the line driven this row is the expected instruction pair
    fetch_checker #(.SAMPLE_DELAY(PERIOD / 2 - 1)) u_checker (
        .clock          (clock),
        .check_en       (check_en),
        .test_name      (cur_name),
        .mask           (cur_mask),
        .exp_addr       (cur_addr),
        .exp_valid      (cur_valid),
        .exp_npc0       (cur_npc0),
        .exp_npc1       (cur_npc1),
        .exp_line       (icache_data),
        .icache_addr    (icache_addr),
        .slot_valid     (slot_valid),
        .slot_inst      (slot_inst),
        .slot_pc        (slot_pc),
        .slot_npc       (slot_npc),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    always #(PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        if_valid      = 1'b0;
        take_branch   = 1'b0;
        branch_target = '0;
        icache_valid  = 1'b0;
        icache_data   = '0;
        ex_br_en      = '0;
        ex_cond_en    = '0;
        ex_pc         = '0;
        ex_tg_pc      = '0;
        ex_taken      = '0;
        check_en      = 1'b0;
        cur_name      = '0;
        cur_mask      = '0;
        cur_addr      = '0;
        cur_valid     = '0;
        cur_npc0      = '0;
        cur_npc1      = '0;
        wait (table_ready);
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // one row per cycle on the falling edge
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clock);
            if_valid      = t_ifv[r];
            icache_valid  = t_icv[r];
            icache_data   = {t_i1[r], t_i0[r]};
            take_branch   = t_redir[r];
            branch_target = t_bt[r];
            ex_br_en      = t_br[r];
            ex_cond_en    = t_cond[r];
            ex_pc         = t_pc[r];
            ex_tg_pc      = t_tg[r];
            ex_taken      = t_taken[r];
            cur_name      = t_name[r];
            cur_mask      = t_mask[r];
            cur_addr      = t_addr[r];
            cur_valid     = t_valid[r];
            cur_npc0      = t_npc0[r];
            cur_npc1      = t_npc1[r];
            check_en      = 1'b1;
        end
        @(negedge clock);
        check_en     = 1'b0;
        if_valid     = 1'b0;
        icache_valid = 1'b0;
        take_branch  = 1'b0;
        ex_br_en     = '0;
        ex_cond_en   = '0;
        @(posedge clock);
        $display("%0d passed, %0d failed, %0d rows", pass_count, fail_count, n_rows);
        if (fail_count == 0 && pass_count == n_rows) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((RESET_CYCLES + n_rows + SLACK_CYCLES) * PERIOD);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("tests failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/branch_predecode.sv
verilog/branch_target_buffer.sv
verilog/branch_direction_predictor.sv
verilog/next_pc_select.sv
verilog/fetch_stage.sv
tests/fetch_checker.sv
tests/fetch_stage_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/branch_predecode.sv
      - verilog/branch_target_buffer.sv
      - verilog/branch_direction_predictor.sv
      - verilog/next_pc_select.sv
      - verilog/fetch_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/fetch_checker.sv
      - tests/fetch_stage_tb.sv
